// ==== Bender.yml ====
package:
  name: tnn_first_layer

sources:
  - include_dirs:
      - .
    files:
      - tnn_pkg.sv
      - feature_sequencer.sv
      - tnn_neuron.sv
      - output_collector.sv
      - tnn_first_layer.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb_tnn_first_layer.sv

// ==== feature_sequencer.sv ====
`include "tnn_cfg.svh"

module feature_sequencer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  tnn_pkg::feature_vec_t features,
  output logic                  step_valid,
  output logic                  busy,
  output tnn_pkg::step_term_t   step
);
  import tnn_pkg::*;

  localparam int IDX_BITS = $clog2(`TNN_FEAT_CNT);
  localparam logic [IDX_BITS-1:0] LAST_IDX = IDX_BITS'(`TNN_FEAT_CNT - 1);

  feature_vec_t        feat_q;
  logic [IDX_BITS-1:0] idx_q;
  logic                tail_q;
  logic                accept;

  // a start that arrives during a run is dropped.
  assign accept = start && !busy;

  always_ff @(posedge clk) begin
    if (accept) begin
      feat_q <= features;
    end
  end

  // busy stays high for one tail cycle after the last step so that it
  // falls together with the collector's done pulse.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      step_valid <= 1'b0;
      busy       <= 1'b0;
      idx_q      <= '0;
      tail_q     <= 1'b0;
    end else begin
      tail_q <= 1'b0;
      if (accept) begin
        step_valid <= 1'b1;
        busy       <= 1'b1;
        idx_q      <= '0;
      end else if (step_valid) begin
        if (idx_q == LAST_IDX) begin
          step_valid <= 1'b0;
          tail_q     <= 1'b1;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end else if (tail_q) begin
        busy <= 1'b0;
      end
    end
  end

  always_comb begin
    step.index = idx_q;
    step.value = feat_q[idx_q];
    step.last  = (idx_q == LAST_IDX);
  end

  // every run is exactly one dense sweep over all feature indices.
  a_sweep_len: assert property (@(posedge clk) disable iff (rst)
    $rose(step_valid) |-> step_valid [*`TNN_FEAT_CNT] ##1 !step_valid);

endmodule

// ==== output_collector.sv ====
module output_collector (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   step_valid,
  input  tnn_pkg::step_term_t    step,
  input  tnn_pkg::layer_result_t neuron_bits,
  output tnn_pkg::layer_result_t out,
  output logic                   done
);

  logic last_q;

  // the neurons take the final term on the same edge that sets last_q,
  // so their sign bits are settled one cycle later.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      last_q <= 1'b0;
      done   <= 1'b0;
      out    <= '0;
    end else begin
      last_q <= step_valid && step.last;
      done   <= last_q;
      if (last_q) begin
        out <= neuron_bits;
      end
    end
  end

  // done is a strobe; two sweeps cannot end on back to back cycles.
  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    done |=> !done);

endmodule

// ==== tb_tnn_first_layer.sv ====
`include "tnn_cfg.svh"

module tb_tnn_first_layer;
  import tnn_pkg::*;

  localparam int FC = `TNN_FEAT_CNT;
  localparam int HC = `TNN_HIDDEN_CNT;
  localparam int VEC_W = `TNN_FEAT_CNT * `TNN_FEAT_BITS;
  localparam int NUM_VEC = 30;
  localparam int LATENCY = FC + 1;
  localparam int DONE_TIMEOUT = 4 * FC + 8;

  // the vector used for the start-while-busy case.
  localparam int BUSY_VEC = 6;

  logic          clk;
  logic          rst;
  logic          start;
  feature_vec_t  features;
  layer_result_t out_bits;
  logic          done;
  logic          busy;

  // each entry is the feature word above the expected output bits.
  logic [VEC_W+HC-1:0] vectors [0:NUM_VEC-1];

  logic [31:0]   rng_state;
  layer_result_t held_out;

  tnn_first_layer UUT (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .features (features),
    .out      (out_bits),
    .done     (done),
    .busy     (busy)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // reference model of the layer, built straight from the weight macros.
  // neuron n adds feature j for weight +1, subtracts it for weight -1 and
  // skips it for weight 0, then reports whether the sum is not negative.
  function automatic logic [HC-1:0] model_bits(input logic [VEC_W-1:0] word);
    logic [HC*FC-1:0] mask;
    logic [HC*FC-1:0] sign;
    logic [HC-1:0]    bits;
    int               sum;
    int               feat;
    mask = `TNN_MASK_WORD;
    sign = `TNN_SIGN_WORD;
    bits = '0;
    for (int n = 0; n < HC; n++) begin
      sum = 0;
      for (int j = 0; j < FC; j++) begin
        feat = int'(word[j*`TNN_FEAT_BITS +: `TNN_FEAT_BITS]);
        if (mask[n*FC+j]) begin
          if (sign[n*FC+j]) begin
            sum = sum + feat;
          end else begin
            sum = sum - feat;
          end
        end
      end
      bits[n] = (sum >= 0);
    end
    return bits;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED: %s actual=0x%h expected=0x%h", name, actual, expected);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  // idle cycles after a result. Nothing may move while the layer rests.
  task automatic idle_hold(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
      check_value("done", done, 0);
      check_value("busy", busy, 0);
      check_value("out", out_bits, held_out);
    end
  endtask

  // pulse start with one feature word and wait for done. With inject set,
  // a second start arrives in the middle of the sweep and must be ignored.
  task automatic run_vector(input logic [VEC_W-1:0] word,
                            input logic [HC-1:0] expected, input bit inject);
    int cycles;
    bit got_done;
    cycles = 0;
    got_done = 1'b0;
    start = 1'b1;
    features = word;
    @(posedge clk);
    #1;
    start = 1'b0;
    // the sequencer keeps its own copy, so the port is free to change now.
    features = ~word;
    while (!got_done) begin
      @(posedge clk);
      #1;
      start = 1'b0;
      cycles++;
      if (done) begin
        got_done = 1'b1;
      end else if (cycles > DONE_TIMEOUT) begin
        $display("done never arrived within %0d cycles after start", DONE_TIMEOUT);
        $display("Test failures found");
        $fatal(1);
      end else begin
        check_value("busy", busy, 1);
        check_value("out", out_bits, held_out);
        if (inject && cycles == 2) begin
          start = 1'b1;
          features = '0;
        end
      end
    end
    check_value("done latency", cycles, LATENCY);
    check_value("out", out_bits, expected);
    check_value("busy", busy, 0);
    held_out = out_bits;
  endtask

  initial begin
    int gap;
    int max_idx;
    logic [VEC_W-1:0] word;
    logic [HC-1:0] expected;

    rst = 1'b1;
    start = 1'b0;
    features = '0;
    rng_state = 32'd79408;
    held_out = '0;
    max_idx = -1;

    $readmemh("tnn_input.mem", vectors);
    for (int i = 0; i < NUM_VEC; i++) begin
      if ($isunknown(vectors[i])) begin
        $display("stimulus file tnn_input.mem is missing or has too few entries");
        $display("Test failures found");
        $fatal(1);
      end
    end

    // the stored expectations must agree with the ternary neuron rule.
    for (int i = 0; i < NUM_VEC; i++) begin
      word = vectors[i][VEC_W+HC-1:HC];
      expected = vectors[i][HC-1:0];
      check_value("file expected bits", expected, model_bits(word));
    end

    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    // state right after reset.
    check_value("done", done, 0);
    check_value("busy", busy, 0);
    check_value("out", out_bits, 0);
    idle_hold(2);

    // every file vector, with short random gaps between runs.
    for (int i = 0; i < NUM_VEC; i++) begin
      word = vectors[i][VEC_W+HC-1:HC];
      expected = vectors[i][HC-1:0];
      run_vector(word, expected, 1'b0);
      rng_state = xorshift32(rng_state);
      gap = int'(rng_state[1:0]);
      idle_hold(gap);
    end

    // the last result has to survive a longer pause.
    idle_hold(3 * FC);

    // a start during a sweep changes nothing and adds no done.
    word = vectors[BUSY_VEC][VEC_W+HC-1:HC];
    expected = vectors[BUSY_VEC][HC-1:0];
    run_vector(word, expected, 1'b1);
    idle_hold(2 * FC + 2);

    // all zero features give zero sums, and zero counts as positive.
    run_vector('0, {HC{1'b1}}, 1'b0);
    idle_hold(1);

    // all-maximum features take their signs from the file.
    for (int i = 0; i < NUM_VEC; i++) begin
      if (vectors[i][VEC_W+HC-1:HC] == {VEC_W{1'b1}}) begin
        max_idx = i;
      end
    end
    if (max_idx < 0) begin
      $display("stimulus file has no vector with all features at maximum");
      $display("Test failures found");
      $fatal(1);
    end else begin
      run_vector({VEC_W{1'b1}}, vectors[max_idx][HC-1:0], 1'b0);
      idle_hold(4);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== tnn_cfg.svh ====
`ifndef TNN_CFG_SVH
`define TNN_CFG_SVH

// number of input features presented to the layer.
`define TNN_FEAT_CNT 4

// width of one unsigned input feature.
`define TNN_FEAT_BITS 4

// number of hidden neurons in the first layer.
`define TNN_HIDDEN_CNT 4

// nonzero weight masks, neuron n owns bits [n*TNN_FEAT_CNT +: TNN_FEAT_CNT].
`define TNN_MASK_WORD 16'hD6FB

// weight signs in the same layout as the mask word. A 1 selects +1.
`define TNN_SIGN_WORD 16'h1459

// the sum of TNN_FEAT_CNT features needs the feature width plus count bits,
// and one more bit carries the sign.
`define TNN_ACC_BITS (`TNN_FEAT_BITS + $clog2(`TNN_FEAT_CNT) + 1)

`endif

// ==== tnn_first_layer.sv ====
`include "tnn_cfg.svh"

module tnn_first_layer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  tnn_pkg::feature_vec_t  features,
  output tnn_pkg::layer_result_t out,
  output logic                   done,
  output logic                   busy
);
  import tnn_pkg::*;

  localparam int FC = `TNN_FEAT_CNT;
  localparam logic [`TNN_HIDDEN_CNT*FC-1:0] MASK_WORD = `TNN_MASK_WORD;
  localparam logic [`TNN_HIDDEN_CNT*FC-1:0] SIGN_WORD = `TNN_SIGN_WORD;

  logic          step_valid;
  step_term_t    step;
  layer_result_t neuron_bits;

  feature_sequencer u_sequencer (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .features   (features),
    .step_valid (step_valid),
    .busy       (busy),
    .step       (step)
  );

  // each row packs the neuron's sign slice above its mask slice.
  for (genvar n = 0; n < `TNN_HIDDEN_CNT; n++) begin : g_neuron
    tnn_neuron #(
      .ROW ({SIGN_WORD[n*FC +: FC], MASK_WORD[n*FC +: FC]})
    ) u_neuron (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .step_valid (step_valid),
      .step       (step),
      .sign_out   (neuron_bits.neuron[n])
    );
  end

  output_collector u_collector (
    .clk         (clk),
    .rst         (rst),
    .step_valid  (step_valid),
    .step        (step),
    .neuron_bits (neuron_bits),
    .out         (out),
    .done        (done)
  );

endmodule

// ==== tnn_input.mem ====
// each line holds the feature word with feature 3 in the top hex digit,
// followed by one hex digit of expected out bits with neuron 0 in the low bit.
0000F
FFFF7
0001F
00108
01007
10005
1234B
43215
000FF
00F08
0F007
F0005
5A3C7
07F9A
3C6E7
91821
2D5FF
6B477
A0C31
00A58
0505F
1E0FF
77777
05306
20559
23543
04532
45504
44500
369CB

// ==== tnn_neuron.sv ====
`include "tnn_cfg.svh"

module tnn_neuron #(
  parameter logic [2*`TNN_FEAT_CNT-1:0] ROW = '0
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  logic                step_valid,
  input  tnn_pkg::step_term_t step,
  output logic                sign_out
);
  import tnn_pkg::*;

  localparam int ACC_BITS = `TNN_ACC_BITS;
  localparam weight_row_u WEIGHTS = weight_row_u'(ROW);

  logic signed [ACC_BITS-1:0] acc_q;
  logic signed [ACC_BITS-1:0] term;
  logic                       use_term;
  logic                       add_term;
  logic                       clear;

  // features are unsigned, so the term is zero extended before the add.
  assign term = $signed({{(ACC_BITS-`TNN_FEAT_BITS){1'b0}}, step.value});

  assign use_term = step_valid && WEIGHTS.fields.mask[step.index];
  assign add_term = WEIGHTS.fields.sign[step.index];

  // the sequencer only accepts start while no step is in flight, so a start
  // seen during a sweep must not disturb the running sum.
  assign clear = start && !step_valid;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      acc_q <= '0;
    end else if (clear) begin
      acc_q <= '0;
    end else if (use_term) begin
      if (add_term) begin
        acc_q <= acc_q + term;
      end else begin
        acc_q <= acc_q - term;
      end
    end
  end

  // a zero sum counts as positive.
  assign sign_out = ~acc_q[ACC_BITS-1];

  // outside a sweep only a new start may move the sum.
  a_acc_hold: assert property (@(posedge clk) disable iff (rst)
    (!step_valid && !start) |=> $stable(acc_q));

endmodule

// ==== tnn_pkg.sv ====
`include "tnn_cfg.svh"

package tnn_pkg;

  // all input features of one inference, feature 0 in the low bits.
  typedef logic [`TNN_FEAT_CNT-1:0][`TNN_FEAT_BITS-1:0] feature_vec_t;

  // one term of the dense feature sweep, broadcast to every neuron.
  typedef struct packed {
    logic [$clog2(`TNN_FEAT_CNT)-1:0] index;
    logic [`TNN_FEAT_BITS-1:0]        value;
    logic                             last;
  } step_term_t;

  // decoded view of a ternary weight row.
  typedef struct packed {
    logic [`TNN_FEAT_CNT-1:0] sign;
    logic [`TNN_FEAT_CNT-1:0] mask;
  } weight_fields_t;

  // the raw row is what gets stored per neuron, the fields are what the
  // accumulator looks at. Bit j of mask and sign both belong to feature j.
  typedef union packed {
    logic [2*`TNN_FEAT_CNT-1:0] raw;
    weight_fields_t             fields;
  } weight_row_u;

  // one sign bit per hidden neuron.
  typedef struct packed {
    logic [`TNN_HIDDEN_CNT-1:0] neuron;
  } layer_result_t;

endpackage

// ==== vlog.f ====
+incdir+.
tnn_pkg.sv
feature_sequencer.sv
tnn_neuron.sv
output_collector.sv
tnn_first_layer.sv
tb_tnn_first_layer.sv
